// File: common/sorter_macros.svh
// Sorter macros: data width, maximum job length and base run size of the merge sorter
`ifndef SORTER_MACROS_SVH
`define SORTER_MACROS_SVH

// Width of one unsigned data word
`define SORT_DATA_WIDTH 16

// Longest job the banks can hold
`define SORT_MAX_LENGTH 32

// Length of a base run built by the chunk sorter
`define SORT_CHUNK_SIZE 8

`endif

// File: common/sorter_pkg.sv
// Sorter package: word, length and index types, chunk and job structs, FSM state encodings
`include "sorter_macros.svh"

package sorter_pkg;

    // One data word
    typedef logic [`SORT_DATA_WIDTH-1:0] sort_data_t;

    // Job length, 0 up to the maximum length inclusive
    typedef logic [$clog2(`SORT_MAX_LENGTH+1)-1:0] sort_len_t;

    // Word position within a bank
    typedef logic [$clog2(`SORT_MAX_LENGTH)-1:0] sort_index_t;

    // Number of valid words in a chunk, 0 up to the chunk size
    typedef logic [$clog2(`SORT_CHUNK_SIZE+1)-1:0] chunk_count_t;

    // One sorted chunk, word 0 is the smallest
    typedef struct packed {
        sort_data_t [`SORT_CHUNK_SIZE-1:0] words;
        sort_index_t                       base;
        chunk_count_t                      count;
    } chunk_t;

    // Job information sent along with every chunk
    typedef struct packed {
        sort_len_t length;
        logic      final_chunk;
    } sort_job_t;

    typedef enum logic {
        CHUNK_IDLE,
        CHUNK_COLLECT
    } chunk_state_t;

    typedef enum logic [1:0] {
        MERGE_IDLE,
        MERGE_LOAD,
        MERGE_MERGE,
        MERGE_READY
    } merge_state_t;

endpackage

// File: chunk_sorter/chunk_sorter.sv
// Chunk sorter: insertion-sorts incoming words into runs of up to eight and issues each run
`include "sorter_macros.svh"

module chunk_sorter (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  sorter_pkg::sort_len_t length,
    input  logic                  in_valid,
    input  sorter_pkg::sort_data_t in_data,
    input  logic                  job_done,
    output logic                  chunk_valid,
    output sorter_pkg::chunk_t    chunk,
    output sorter_pkg::sort_job_t job,
    output logic                  busy
);

    sorter_pkg::chunk_state_t state;
    sorter_pkg::sort_len_t    job_length;
    sorter_pkg::sort_len_t    word_count;
    sorter_pkg::sort_len_t    next_count;
    sorter_pkg::chunk_count_t fill;
    sorter_pkg::chunk_count_t next_fill;
    sorter_pkg::sort_index_t  chunk_base;

    sorter_pkg::sort_data_t [`SORT_CHUNK_SIZE-1:0] sorted_words;
    sorter_pkg::sort_data_t [`SORT_CHUNK_SIZE-1:0] inserted;
    logic [`SORT_CHUNK_SIZE-1:0] keep;

    logic accept;
    logic job_last;
    logic chunk_done;

    assign accept     = (state == sorter_pkg::CHUNK_COLLECT) && in_valid;
    assign next_count = word_count + 1'b1;
    assign next_fill  = fill + 1'b1;
    assign job_last   = (next_count == job_length);
    assign chunk_done = accept &&
        (job_last || next_fill == sorter_pkg::chunk_count_t'(`SORT_CHUNK_SIZE));

    // Compare-and-shift insertion. Entries that are not larger than the new
    // word stay put, so equal words keep their arrival order
    always_comb begin
        for (int i = 0; i < `SORT_CHUNK_SIZE; i++) begin
            keep[i] = (sorter_pkg::chunk_count_t'(i) < fill) && (sorted_words[i] <= in_data);
        end
        inserted[0] = keep[0] ? sorted_words[0] : in_data;
        for (int i = 1; i < `SORT_CHUNK_SIZE; i++) begin
            if (keep[i]) begin
                inserted[i] = sorted_words[i];
            end else if (keep[i-1]) begin
                inserted[i] = in_data;
            end else begin
                inserted[i] = sorted_words[i-1];
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= sorter_pkg::CHUNK_IDLE;
            busy        <= 1'b0;
            chunk_valid <= 1'b0;
            job_length  <= '0;
            word_count  <= '0;
            fill        <= '0;
            chunk_base  <= '0;
        end else begin
            chunk_valid <= 1'b0;
            if (job_done) begin
                busy <= 1'b0;
            end
            case (state)
                sorter_pkg::CHUNK_IDLE: begin
                    // A start while a job is still in flight is dropped
                    if (start && !busy && length != '0) begin
                        state      <= sorter_pkg::CHUNK_COLLECT;
                        busy       <= 1'b1;
                        job_length <= length;
                        word_count <= '0;
                        fill       <= '0;
                        chunk_base <= '0;
                    end
                end
                sorter_pkg::CHUNK_COLLECT: begin
                    if (accept) begin
                        word_count <= next_count;
                        fill       <= next_fill;
                        if (chunk_done) begin
                            chunk_valid <= 1'b1;
                            fill        <= '0;
                            chunk_base  <= chunk_base +
                                sorter_pkg::sort_index_t'(`SORT_CHUNK_SIZE);
                            if (job_last) begin
                                state <= sorter_pkg::CHUNK_IDLE;
                            end
                        end
                    end
                end
                default: state <= sorter_pkg::CHUNK_IDLE;
            endcase
        end
    end

    // The issued chunk takes the array including the word that completed it
    always_ff @(posedge clock) begin
        if (accept) begin
            sorted_words <= inserted;
        end
        if (chunk_done) begin
            chunk.words     <= inserted;
            chunk.base      <= chunk_base;
            chunk.count     <= next_fill;
            job.length      <= job_length;
            job.final_chunk <= job_last;
        end
    end

endmodule

// File: merge_engine/merge_engine.sv
// Merge engine: stores sorted chunks and merges run pairs between two banks until one run is left
`include "sorter_macros.svh"

module merge_engine (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   chunk_valid,
    input  sorter_pkg::chunk_t     chunk,
    input  sorter_pkg::sort_job_t  job,
    input  sorter_pkg::sort_index_t rd_index,
    output sorter_pkg::sort_data_t rd_data,
    output logic                   result_ready,
    output sorter_pkg::sort_len_t  result_length
);

    // Bank 0 is bank A, where chunks land
    sorter_pkg::sort_data_t banks [2][`SORT_MAX_LENGTH];

    sorter_pkg::merge_state_t state;
    logic                     src_sel;
    logic                     dst_sel;
    logic                     pass_start;
    sorter_pkg::sort_len_t    job_length;
    sorter_pkg::sort_len_t    run_width;
    sorter_pkg::sort_len_t    next_width;

    // Read pointers and limits of the run pair being merged
    sorter_pkg::sort_len_t left_ptr;
    sorter_pkg::sort_len_t left_end;
    sorter_pkg::sort_len_t right_ptr;
    sorter_pkg::sort_len_t right_end;
    sorter_pkg::sort_len_t out_ptr;

    sorter_pkg::sort_len_t pair_base;
    sorter_pkg::sort_len_t mid_sum;
    sorter_pkg::sort_len_t top_sum;
    sorter_pkg::sort_len_t pair_mid;
    sorter_pkg::sort_len_t pair_top;

    sorter_pkg::sort_data_t left_head;
    sorter_pkg::sort_data_t right_head;
    sorter_pkg::sort_data_t merge_word;
    logic left_live;
    logic right_live;
    logic take_left;
    logic merge_write;
    logic pass_end;
    logic pair_end;

    assign dst_sel    = !src_sel;
    assign next_width = run_width << 1;

    assign left_head  = banks[src_sel][sorter_pkg::sort_index_t'(left_ptr)];
    assign right_head = banks[src_sel][sorter_pkg::sort_index_t'(right_ptr)];
    assign left_live  = left_ptr < left_end;
    assign right_live = right_ptr < right_end;
    // Ties go to the left run to keep the merge stable
    assign take_left  = left_live && (!right_live || left_head <= right_head);
    assign merge_word = take_left ? left_head : right_head;

    assign merge_write = (state == sorter_pkg::MERGE_MERGE) && !pass_start;
    assign pass_end    = (out_ptr + 1'b1 == job_length);
    assign pair_end    = (out_ptr + 1'b1 == right_end);

    // Limits of the next pair, clipped to the job length for short tail runs
    assign pair_base = pass_start ? '0 : right_end;
    assign mid_sum   = pair_base + run_width;
    assign top_sum   = pair_base + next_width;
    assign pair_mid  = (mid_sum < job_length) ? mid_sum : job_length;
    assign pair_top  = (top_sum < job_length) ? top_sum : job_length;

    assign result_length = job_length;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state        <= sorter_pkg::MERGE_IDLE;
            src_sel      <= 1'b0;
            pass_start   <= 1'b0;
            job_length   <= '0;
            run_width    <= '0;
            left_ptr     <= '0;
            left_end     <= '0;
            right_ptr    <= '0;
            right_end    <= '0;
            out_ptr      <= '0;
            result_ready <= 1'b0;
        end else begin
            result_ready <= 1'b0;
            case (state)
                sorter_pkg::MERGE_MERGE: begin
                    if (pass_start) begin
                        pass_start <= 1'b0;
                        out_ptr    <= '0;
                        left_ptr   <= pair_base;
                        left_end   <= pair_mid;
                        right_ptr  <= pair_mid;
                        right_end  <= pair_top;
                    end else begin
                        out_ptr <= out_ptr + 1'b1;
                        if (take_left) begin
                            left_ptr <= left_ptr + 1'b1;
                        end else begin
                            right_ptr <= right_ptr + 1'b1;
                        end
                        if (pass_end) begin
                            src_sel   <= dst_sel;
                            run_width <= next_width;
                            if (next_width >= job_length) begin
                                state        <= sorter_pkg::MERGE_READY;
                                result_ready <= 1'b1;
                            end else begin
                                pass_start <= 1'b1;
                            end
                        end else if (pair_end) begin
                            left_ptr  <= pair_base;
                            left_end  <= pair_mid;
                            right_ptr <= pair_mid;
                            right_end <= pair_top;
                        end
                    end
                end
                default: begin
                    // Idle, load and ready all wait for chunks of the next job
                    if (chunk_valid) begin
                        state <= sorter_pkg::MERGE_LOAD;
                        if (job.final_chunk) begin
                            job_length <= job.length;
                            src_sel    <= 1'b0;
                            run_width  <= sorter_pkg::sort_len_t'(`SORT_CHUNK_SIZE);
                            if (job.length <= sorter_pkg::sort_len_t'(`SORT_CHUNK_SIZE)) begin
                                state        <= sorter_pkg::MERGE_READY;
                                result_ready <= 1'b1;
                            end else begin
                                state      <= sorter_pkg::MERGE_MERGE;
                                pass_start <= 1'b1;
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (chunk_valid) begin
            for (int i = 0; i < `SORT_CHUNK_SIZE; i++) begin
                if (sorter_pkg::chunk_count_t'(i) < chunk.count) begin
                    banks[0][chunk.base + sorter_pkg::sort_index_t'(i)] <= chunk.words[i];
                end
            end
        end
        if (merge_write) begin
            banks[dst_sel][sorter_pkg::sort_index_t'(out_ptr)] <= merge_word;
        end
        rd_data <= banks[src_sel][rd_index];
    end

endmodule

// File: src/sort_drain.sv
// Sort drain: streams the sorted bank out in order, flags the final word and pulses done
module sort_drain (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    result_ready,
    input  sorter_pkg::sort_len_t   result_length,
    input  sorter_pkg::sort_data_t  rd_data,
    output sorter_pkg::sort_index_t rd_index,
    output logic                    out_valid,
    output logic                    out_last,
    output logic                    done,
    output sorter_pkg::sort_data_t  out_data
);

    logic fetching;
    logic fetch;
    logic fetch_last;
    logic pending;
    logic pending_last;

    // Index 0 is already presented in the result_ready cycle
    assign fetch      = result_ready || fetching;
    assign fetch_last = (sorter_pkg::sort_len_t'(rd_index) + 1'b1 == result_length);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_index     <= '0;
            fetching     <= 1'b0;
            pending      <= 1'b0;
            pending_last <= 1'b0;
            out_valid    <= 1'b0;
            out_last     <= 1'b0;
            done         <= 1'b0;
        end else begin
            pending      <= fetch;
            pending_last <= fetch && fetch_last;
            out_valid    <= pending;
            out_last     <= pending_last;
            done         <= out_last;
            if (fetch) begin
                if (fetch_last) begin
                    rd_index <= '0;
                    fetching <= 1'b0;
                end else begin
                    rd_index <= rd_index + 1'b1;
                    fetching <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        out_data <= rd_data;
    end

endmodule

// File: src/merge_sorter.sv
// Merge sorter top: chunk sorter, merge engine and drain connected into one streaming sorter
module merge_sorter (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   start,
    input  sorter_pkg::sort_len_t  length,
    input  logic                   in_valid,
    input  sorter_pkg::sort_data_t in_data,
    output logic                   out_valid,
    output sorter_pkg::sort_data_t out_data,
    output logic                   out_last,
    output logic                   done,
    output logic                   busy
);

    // Chunk path into the merge engine
    logic                  chunk_valid;
    sorter_pkg::chunk_t    chunk;
    sorter_pkg::sort_job_t job;

    // Result handoff and read port between engine and drain
    logic                    result_ready;
    sorter_pkg::sort_len_t   result_length;
    sorter_pkg::sort_index_t rd_index;
    sorter_pkg::sort_data_t  rd_data;

    chunk_sorter i_chunk_sorter (
        .clock       (clock),
        .arst_n      (arst_n),
        .start       (start),
        .length      (length),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .job_done    (done),
        .chunk_valid (chunk_valid),
        .chunk       (chunk),
        .job         (job),
        .busy        (busy)
    );

    merge_engine i_merge_engine (
        .clock         (clock),
        .arst_n        (arst_n),
        .chunk_valid   (chunk_valid),
        .chunk         (chunk),
        .job           (job),
        .rd_index      (rd_index),
        .rd_data       (rd_data),
        .result_ready  (result_ready),
        .result_length (result_length)
    );

    // done also ends busy in the chunk sorter
    sort_drain i_sort_drain (
        .clock         (clock),
        .arst_n        (arst_n),
        .result_ready  (result_ready),
        .result_length (result_length),
        .rd_data       (rd_data),
        .rd_index      (rd_index),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .done          (done),
        .out_data      (out_data)
    );

endmodule

// File: verification/tb_clock_gen.sv
// Testbench clock and reset source: 20 ns clock, reset held low for the first two cycles
module tb_clock_gen (
    output logic clock,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Release on a falling edge so the first active edge sees a clean reset
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

// File: verification/merge_sorter_asserts.sv
// Merge sorter output checks: ascending words per job, last flag, done timing and busy release
module merge_sorter_asserts (
    input logic                   clock,
    input logic                   arst_n,
    input logic                   out_valid,
    input sorter_pkg::sort_data_t out_data,
    input logic                   out_last,
    input logic                   done,
    input logic                   busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Previous word of the job now being streamed
    sorter_pkg::sort_data_t prev_word;
    logic                   in_job;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prev_word <= '0;
            in_job    <= 1'b0;
        end else if (out_valid) begin
            prev_word <= out_data;
            in_job    <= !out_last;
        end
    end

    ascending_output: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid && in_job |-> out_data >= prev_word)
    else begin
        fail_count = fail_count + 1;
        $error("Output word is smaller than the word before it in the same job");
    end

    done_after_last: assert property (@(posedge clock) disable iff (!arst_n)
        out_last |=> done)
    else begin
        fail_count = fail_count + 1;
        $error("done did not follow out_last by one cycle");
    end

    // A done without out_last one cycle earlier is just as wrong
    no_stray_done: assert property (@(posedge clock) disable iff (!arst_n)
        !out_last |=> !done)
    else begin
        fail_count = fail_count + 1;
        $error("done was raised without out_last in the cycle before");
    end

    last_with_valid: assert property (@(posedge clock) disable iff (!arst_n)
        out_last |-> out_valid)
    else begin
        fail_count = fail_count + 1;
        $error("out_last was raised without out_valid");
    end

    idle_after_done: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> !busy)
    else begin
        fail_count = fail_count + 1;
        $error("busy stayed high after done");
    end

endmodule

// File: verification/merge_sorter_tb.sv
// Merge sorter testbench: LFSR jobs of several lengths and patterns checked against a sorted copy
module merge_sorter_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] MODE_RANDOM = 2'd0;
    localparam logic [1:0] MODE_ZEROS  = 2'd1;
    localparam logic [1:0] MODE_ONES   = 2'd2;
    localparam logic [1:0] MODE_FEW    = 2'd3;

    typedef struct packed {
        int         length;
        logic [1:0] mode;
        logic       gaps;
        logic       reuse;
        logic       disturb;
    } job_spec_t;

    logic                   clock;
    logic                   arst_n;
    logic                   start;
    sorter_pkg::sort_len_t  length;
    logic                   in_valid;
    sorter_pkg::sort_data_t in_data;
    logic                   out_valid;
    sorter_pkg::sort_data_t out_data;
    logic                   out_last;
    logic                   done;
    logic                   busy;

    job_spec_t              plan[$];
    sorter_pkg::sort_data_t job_words[$];
    sorter_pkg::sort_data_t expected[$];
    logic [31:0]            lfsr_state;
    int                     exp_length = 0;
    int                     out_index = 0;
    int                     done_count = 0;
    int                     error_count = 0;
    int                     cycle_count = 0;
    int                     timeout_limit = 0;

    tb_clock_gen i_tb_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    merge_sorter i_merge_sorter (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (start),
        .length    (length),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .done      (done),
        .busy      (busy)
    );

    bind merge_sorter merge_sorter_asserts i_merge_sorter_asserts (
        .clock     (clock),
        .arst_n    (arst_n),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .done      (done),
        .busy      (busy)
    );

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] value);
        logic feedback;
        feedback = value[31] ^ value[21] ^ value[1] ^ value[0];
        return {value[30:0], feedback};
    endfunction

    task automatic draw_word(input logic [1:0] mode, output sorter_pkg::sort_data_t word);
        int nbits;
        word  = (mode == MODE_ONES) ? '1 : '0;
        nbits = (mode == MODE_FEW) ? 2 : $bits(word);
        if (mode == MODE_RANDOM || mode == MODE_FEW) begin
            for (int b = 0; b < nbits; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                word = {word[$bits(word)-2:0], lfsr_state[0]};
            end
        end
    endtask

    // Plain insertion sort of the reference copy
    task automatic sort_reference();
        int                     j;
        sorter_pkg::sort_data_t key;
        for (int i = 1; i < expected.size(); i++) begin
            key = expected[i];
            j = i - 1;
            while (j >= 0 && expected[j] > key) begin
                expected[j+1] = expected[j];
                j--;
            end
            expected[j+1] = key;
        end
    endtask

    task automatic add_job(input int len, input logic [1:0] mode, input logic gaps,
                           input logic reuse, input logic disturb);
        job_spec_t spec;
        spec.length  = len;
        spec.mode    = mode;
        spec.gaps    = gaps;
        spec.reuse   = reuse;
        spec.disturb = disturb;
        plan.push_back(spec);
        timeout_limit += 4 * len + 20;
    endtask

    task automatic run_job(input job_spec_t spec);
        sorter_pkg::sort_data_t word;
        if (!spec.reuse) begin
            job_words.delete();
            for (int i = 0; i < spec.length; i++) begin
                draw_word(spec.mode, word);
                job_words.push_back(word);
            end
        end
        expected = job_words;
        sort_reference();
        exp_length = spec.length;
        out_index  = 0;
        start  = 1'b1;
        length = sorter_pkg::sort_len_t'(spec.length);
        @(negedge clock);
        start  = 1'b0;
        length = '0;
        // busy rises on the edge that takes the start
        if (busy !== 1'b1) begin
            error_count++;
            $display("[ERROR] %0t ns busy: expected 1, actual %b", $time, busy);
        end
        for (int i = 0; i < spec.length; i++) begin
            in_valid = 1'b1;
            in_data  = job_words[i];
            // A second start in the middle of the input must be ignored
            if (spec.disturb && i == spec.length / 2) begin
                start  = 1'b1;
                length = sorter_pkg::sort_len_t'(5);
            end
            @(negedge clock);
            start = 1'b0;
            if (spec.gaps) begin
                in_valid = 1'b0;
                @(negedge clock);
            end
        end
        in_valid = 1'b0;
        if (spec.disturb) begin
            for (int i = 0; i < 3; i++) begin
                draw_word(MODE_RANDOM, word);
                in_valid = 1'b1;
                in_data  = word;
                @(negedge clock);
            end
            in_valid = 1'b0;
            start    = 1'b1;
            length   = sorter_pkg::sort_len_t'(7);
            @(negedge clock);
            start  = 1'b0;
            length = '0;
        end
        @(negedge clock);
        while (!done) @(negedge clock);
        // Quiet cycles in which a second done would be counted
        repeat (3) @(negedge clock);
    endtask

    // Outputs settle after the rising edge and are sampled on the falling edge
    always @(negedge clock) begin
        if (arst_n && out_valid) begin
            if (out_index >= exp_length) begin
                error_count++;
                $display("[ERROR] %0t ns: output word %0d is beyond the job length %0d",
                         $time, out_index, exp_length);
            end else if (out_data !== expected[out_index]) begin
                error_count++;
                $display("[ERROR] %0t ns out_data: expected %h, actual %h",
                         $time, expected[out_index], out_data);
            end
            if (out_last != (out_index == exp_length - 1)) begin
                error_count++;
                $display("[ERROR] %0t ns out_last: expected %b, actual %b",
                         $time, out_index == exp_length - 1, out_last);
            end
            out_index++;
        end
        if (arst_n && done) begin
            done_count++;
            if (out_index != exp_length) begin
                error_count++;
                $display("Job ended after %0d output words but its length is %0d",
                         out_index, exp_length);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int jobs_run;
        int assert_fails;
        start      = 1'b0;
        length     = '0;
        in_valid   = 1'b0;
        in_data    = '0;
        lfsr_state = 32'hd909a3e9;
        jobs_run   = 0;
        add_job(8, MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        add_job(16, MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        add_job(32, MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        add_job(1, MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        add_job(5, MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        add_job(13, MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        add_job(27, MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        add_job(20, MODE_ZEROS, 1'b0, 1'b0, 1'b0);
        add_job(32, MODE_ONES, 1'b0, 1'b0, 1'b0);
        add_job(24, MODE_FEW, 1'b0, 1'b0, 1'b0);
        // The same sixteen words, first back to back and then with gaps
        add_job(16, MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        add_job(16, MODE_RANDOM, 1'b1, 1'b1, 1'b0);
        add_job(13, MODE_RANDOM, 1'b0, 1'b0, 1'b1);
        wait (arst_n === 1'b1);
        repeat (2) @(negedge clock);
        for (int j = 0; j < plan.size(); j++) begin
            run_job(plan[j]);
            jobs_run++;
        end
        if (done_count != jobs_run) begin
            error_count++;
            $display("Saw %0d done pulses for %0d jobs", done_count, jobs_run);
        end
        assert_fails = i_merge_sorter.i_merge_sorter_asserts.fail_count;
        $display("Summary: %0d jobs, %0d check errors, %0d assertion failures",
                 jobs_run, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+common
common/sorter_pkg.sv
chunk_sorter/chunk_sorter.sv
merge_engine/merge_engine.sv
src/sort_drain.sv
src/merge_sorter.sv
verification/tb_clock_gen.sv
verification/merge_sorter_asserts.sv
verification/merge_sorter_tb.sv

// File: run.sh
#!/bin/sh
# Build the merge sorter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module merge_sorter_tb -o merge_sorter_sim

output=$(./obj_dir/merge_sorter_sim) || { echo "$output"; exit 1; }
echo "$output"

if echo "$output" | grep -q "^NO ERRORS$"; then
    exit 0
else
    exit 1
fi
